//--- source/opreq_config.svh
////////////////////
// Size parameters of the operand requester stage
// Queues, banks, instruction ids, data widths and register stride
////////////////////

`ifndef OPREQ_CONFIG_SVH
`define OPREQ_CONFIG_SVH

// Operand queues and VRF banks
`define OPREQ_NR_OPQ      4
`define OPREQ_NR_BANKS    4
`define OPREQ_OPQ_W       $clog2(`OPREQ_NR_OPQ)
`define OPREQ_BANK_W      $clog2(`OPREQ_NR_BANKS)

// In-flight instruction ids
`define OPREQ_NR_VINSN    8
`define OPREQ_VID_W       $clog2(`OPREQ_NR_VINSN)

// Lane word address, data word and vector length
`define OPREQ_VADDR_W     8
`define OPREQ_ELEN        64
`define OPREQ_VL_W        9

// Lane words per vector register
`define OPREQ_VREG_WORDS  8

`endif

//--- source/opreq_pkg.sv
////////////////////
// Shared types of the operand requester stage
// Commands, writer payloads and VRF bank accesses
////////////////////

`include "opreq_config.svh"

package opreq_pkg;

  // Basic scalar types
  typedef logic [`OPREQ_VID_W-1:0]                  vid_t;
  typedef logic [`OPREQ_VADDR_W-1:0]                vaddr_t;
  typedef logic [`OPREQ_VADDR_W-`OPREQ_BANK_W-1:0]  baddr_t;
  typedef logic [`OPREQ_ELEN-1:0]                   elen_t;
  typedef logic [`OPREQ_ELEN/8-1:0]                 strb_t;
  typedef logic [`OPREQ_VL_W-1:0]                   vlen_t;
  typedef logic [`OPREQ_OPQ_W-1:0]                  opq_id_t;
  typedef logic [`OPREQ_NR_BANKS-1:0]               bank_mask_t;
  typedef logic [`OPREQ_NR_VINSN-1:0]               vinsn_mask_t;
  typedef logic [4:0]                               vreg_t;

  // Element width code giving 8 >> code elements per word
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Read command from the lane sequencer
  typedef struct packed {
    vreg_t       vs;
    vlen_t       vstart;
    vew_e        eew;
    vlen_t       vl;
    vinsn_mask_t hazard;
  } opq_req_t;

  // Command towards an operand queue
  typedef struct packed {
    vew_e  eew;
    vlen_t vl;
  } opq_cmd_t;

  // Result writer payload
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_req_t;

  // One access on a VRF bank port
  typedef struct packed {
    baddr_t  addr;
    logic    wen;
    elen_t   wdata;
    strb_t   be;
    opq_id_t tgt_opq;
  } vrf_req_t;

  // Requester engine
  typedef enum logic {
    IDLE,
    REQUESTING
  } opreq_state_e;

  typedef struct packed {
    vaddr_t      addr;
    vlen_t       len;
    vew_e        eew;
    vinsn_mask_t hazard;
  } opreq_ctx_t;

endpackage

//--- source/result_tracker.sv
////////////////////
// Load unit stream register and the
// registered written-by-instruction vector
////////////////////

`timescale 1ns/1ps
`include "opreq_config.svh"

module result_tracker import opreq_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Load unit side
  input  logic        ldu_req_i,
  input  result_req_t ldu_i,
  output logic        ldu_gnt_o,
  // Registered copy towards the arbiter
  output logic        ldu_req_o,
  output result_req_t ldu_o,
  input  logic        ldu_gnt_i,
  // ALU grant as seen by the arbiter
  input  logic        alu_gnt_i,
  input  vid_t        alu_id_i,
  // One bit per instruction that wrote last cycle
  output vinsn_mask_t result_written_o
);

  ////////////////////
  // Stream register
  ////////////////////

  logic        ldu_valid_q;
  result_req_t ldu_q;

  // Accept while empty or while the held word leaves this cycle
  assign ldu_gnt_o = ldu_req_i && (!ldu_valid_q || ldu_gnt_i);
  assign ldu_req_o = ldu_valid_q;
  assign ldu_o     = ldu_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q <= 1'b0;
    end else if (ldu_gnt_o) begin
      ldu_valid_q <= 1'b1;
    end else if (ldu_gnt_i) begin
      ldu_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_gnt_o) begin
      ldu_q <= ldu_i;
    end
  end

  ////////////////////
  // Written vector
  ////////////////////

  vinsn_mask_t written_d;
  vinsn_mask_t written_q;

  always_comb begin
    written_d = '0;
    written_d[alu_id_i] = alu_gnt_i;
    // The load write counts when its registered copy lands
    if (ldu_gnt_i) begin
      written_d[ldu_q.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else begin
      written_q <= written_d;
    end
  end

  assign result_written_o = written_q;

  // A load write that is not granted is held unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_req_i && !ldu_gnt_o |=> ldu_req_i && $stable(ldu_i))
    else $error("load write changed or dropped before its grant");

endmodule

//--- source/operand_requester.sv
////////////////////
// Operand requester for one queue
// Walks a vector register and requests one word per grant
////////////////////

`timescale 1ns/1ps
`include "opreq_config.svh"

module operand_requester import opreq_pkg::*; #(
  parameter opq_id_t QUEUE_ID = '0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Read command
  input  logic        req_valid_i,
  input  opq_req_t    req_i,
  output logic        req_ready_o,
  // Operand queue and hazard status
  input  logic        opq_ready_i,
  input  vinsn_mask_t result_written_i,
  input  vinsn_mask_t vinsn_running_i,
  // VRF arbiter
  output bank_mask_t  bank_req_o,
  output vrf_req_t    vrf_o,
  input  bank_mask_t  bank_gnt_i,
  // Operand queue
  output logic        issued_o,
  output opq_cmd_t    cmd_o,
  output logic        cmd_valid_o
);

  // Number of elements packed in one 64-bit word
  function automatic vlen_t elems_per_word(input vew_e eew);
    return vlen_t'(1) << (int'(EW64) - int'(eew));
  endfunction

  // Context of a freshly accepted command
  function automatic opreq_ctx_t load_ctx(input opq_req_t req);
    opreq_ctx_t ctx;
    ctx.addr   = vaddr_t'(req.vs) * vaddr_t'(`OPREQ_VREG_WORDS) +
                 vaddr_t'(req.vstart >> (int'(EW64) - int'(req.eew)));
    ctx.len    = req.vl;
    ctx.eew    = req.eew;
    ctx.hazard = req.hazard;
    return ctx;
  endfunction

  opreq_state_e                state_d;
  opreq_state_e                state_q;
  opreq_ctx_t                  ctx_d;
  opreq_ctx_t                  ctx_q;
  logic [`OPREQ_BANK_W-1:0]    bank;
  vlen_t                       epw;
  logic                        stall;
  logic                        gnt;
  logic                        accept;

  assign bank = ctx_q.addr[`OPREQ_BANK_W-1:0];
  assign epw  = elems_per_word(ctx_q.eew);
  assign gnt  = |bank_gnt_i;

  // Hold back while a producer has not written in the last cycle
  assign stall = |(ctx_q.hazard & ~result_written_i);

  assign issued_o = gnt;
  assign cmd_o    = '{eew: req_i.eew, vl: req_i.vl};

  // Reads carry the bank-local address and their target queue
  assign vrf_o = '{
    addr:    ctx_q.addr[`OPREQ_VADDR_W-1:`OPREQ_BANK_W],
    wen:     1'b0,
    wdata:   '0,
    be:      '0,
    tgt_opq: QUEUE_ID
  };

  always_comb begin
    state_d     = state_q;
    ctx_d       = ctx_q;
    bank_req_o  = '0;
    req_ready_o = 1'b0;
    cmd_valid_o = 1'b0;
    accept      = 1'b0;

    case (state_q)
      IDLE: begin
        accept = 1'b1;
      end
      REQUESTING: begin
        // Finished producers no longer block
        ctx_d.hazard = ctx_q.hazard & vinsn_running_i;
        if (opq_ready_i && !stall) begin
          bank_req_o[bank] = 1'b1;
        end
        if (gnt) begin
          ctx_d.addr = ctx_q.addr + vaddr_t'(1);
          ctx_d.len  = (ctx_q.len <= epw) ? '0 : ctx_q.len - epw;
          if (ctx_d.len == '0) begin
            state_d = IDLE;
            accept  = 1'b1;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // Accept a new command and drop one of zero length
    if (accept && req_valid_i) begin
      req_ready_o = 1'b1;
      ctx_d       = load_ctx(req_i);
      if (req_i.vl != '0) begin
        cmd_valid_o = 1'b1;
        state_d     = REQUESTING;
      end else begin
        state_d     = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ctx_q   <= '0;
    end else begin
      state_q <= state_d;
      ctx_q   <= ctx_d;
    end
  end

  // Only one bank is asked for at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_req_o))
    else $error("requester asks for more than one bank");

endmodule

//--- source/vrf_arbiter.sv
////////////////////
// Per-bank two-class round-robin arbiter
// Reads and result writes onto the VRF ports
////////////////////

`timescale 1ns/1ps
`include "opreq_config.svh"

module vrf_arbiter import opreq_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Operand requesters
  input  bank_mask_t [`OPREQ_NR_OPQ-1:0]      rd_req_i,
  input  vrf_req_t   [`OPREQ_NR_OPQ-1:0]      rd_i,
  output bank_mask_t [`OPREQ_NR_OPQ-1:0]      rd_gnt_o,
  // ALU writer
  input  logic                                alu_req_i,
  input  result_req_t                         alu_i,
  output logic                                alu_gnt_o,
  // Registered load writer
  input  logic                                ldu_req_i,
  input  result_req_t                         ldu_i,
  output logic                                ldu_gnt_o,
  // VRF bank ports
  output bank_mask_t                          vrf_req_o,
  output vrf_req_t   [`OPREQ_NR_BANKS-1:0]    vrf_o
);

  // Each class holds half the queues plus one writer
  localparam int unsigned HALF    = `OPREQ_NR_OPQ / 2;
  localparam int unsigned CLASS_N = HALF + 1;
  localparam int unsigned PTR_W   = $clog2(CLASS_N);

  // First requester at or after the pointer, in cyclic order
  function automatic logic [CLASS_N-1:0] rr_pick(input logic [CLASS_N-1:0] req,
                                                 input logic [PTR_W-1:0] ptr);
    logic [CLASS_N-1:0] pick;
    int                 idx;
    pick = '0;
    for (int i = CLASS_N - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % CLASS_N;
      if (req[idx]) begin
        pick      = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // Pointer moves just past the granted member
  function automatic logic [PTR_W-1:0] rr_next(input logic [CLASS_N-1:0] pick,
                                               input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = ptr;
    for (int i = 0; i < CLASS_N; i++) begin
      if (pick[i]) begin
        nxt = (i == CLASS_N - 1) ? '0 : PTR_W'(i + 1);
      end
    end
    return nxt;
  endfunction

  function automatic vrf_req_t make_write(input result_req_t wr);
    return '{addr: wr.addr[`OPREQ_VADDR_W-1:`OPREQ_BANK_W], wen: 1'b1,
             wdata: wr.wdata, be: wr.be, tgt_opq: '0};
  endfunction

  bank_mask_t                                    alu_bank_req;
  bank_mask_t                                    ldu_bank_req;
  vrf_req_t   [CLASS_N-1:0]                      hp_pay;
  vrf_req_t   [CLASS_N-1:0]                      lp_pay;
  logic       [`OPREQ_NR_BANKS-1:0][CLASS_N-1:0] hp_req;
  logic       [`OPREQ_NR_BANKS-1:0][CLASS_N-1:0] lp_req;
  logic       [`OPREQ_NR_BANKS-1:0][CLASS_N-1:0] hp_gnt;
  logic       [`OPREQ_NR_BANKS-1:0][CLASS_N-1:0] lp_gnt;
  logic       [`OPREQ_NR_BANKS-1:0][PTR_W-1:0]   hp_ptr_q;
  logic       [`OPREQ_NR_BANKS-1:0][PTR_W-1:0]   lp_ptr_q;

  ////////////////////
  // Request matrix
  ////////////////////

  always_comb begin
    alu_bank_req = '0;
    ldu_bank_req = '0;
    alu_bank_req[alu_i.addr[`OPREQ_BANK_W-1:0]] = alu_req_i;
    ldu_bank_req[ldu_i.addr[`OPREQ_BANK_W-1:0]] = ldu_req_i;
    for (int i = 0; i < HALF; i++) begin
      hp_pay[i] = rd_i[i];
      lp_pay[i] = rd_i[HALF+i];
    end
    hp_pay[HALF] = make_write(alu_i);
    lp_pay[HALF] = make_write(ldu_i);
  end

  // High class masks the low class on a bank
  always_comb begin
    for (int b = 0; b < `OPREQ_NR_BANKS; b++) begin
      for (int i = 0; i < HALF; i++) begin
        hp_req[b][i] = rd_req_i[i][b];
        lp_req[b][i] = rd_req_i[HALF+i][b];
      end
      hp_req[b][HALF] = alu_bank_req[b];
      lp_req[b][HALF] = ldu_bank_req[b];
      hp_gnt[b] = rr_pick(hp_req[b], hp_ptr_q[b]);
      lp_gnt[b] = (|hp_req[b]) ? '0 : rr_pick(lp_req[b], lp_ptr_q[b]);
    end
  end

  ////////////////////
  // Grants and ports
  ////////////////////

  always_comb begin
    rd_gnt_o  = '0;
    alu_gnt_o = 1'b0;
    ldu_gnt_o = 1'b0;
    for (int b = 0; b < `OPREQ_NR_BANKS; b++) begin
      vrf_req_o[b] = (|hp_gnt[b]) || (|lp_gnt[b]);
      vrf_o[b]     = '0;
      for (int i = 0; i < CLASS_N; i++) begin
        if (hp_gnt[b][i]) vrf_o[b] = hp_pay[i];
        if (lp_gnt[b][i]) vrf_o[b] = lp_pay[i];
      end
      for (int i = 0; i < HALF; i++) begin
        rd_gnt_o[i][b]      = hp_gnt[b][i];
        rd_gnt_o[HALF+i][b] = lp_gnt[b][i];
      end
      alu_gnt_o = alu_gnt_o | hp_gnt[b][HALF];
      ldu_gnt_o = ldu_gnt_o | lp_gnt[b][HALF];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hp_ptr_q <= '0;
      lp_ptr_q <= '0;
    end else begin
      for (int b = 0; b < `OPREQ_NR_BANKS; b++) begin
        hp_ptr_q[b] <= rr_next(hp_gnt[b], hp_ptr_q[b]);
        lp_ptr_q[b] <= rr_next(lp_gnt[b], lp_ptr_q[b]);
      end
    end
  end

  for (genvar b = 0; b < `OPREQ_NR_BANKS; b++) begin : gen_bank_check
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0({hp_gnt[b], lp_gnt[b]}))
      else $error("more than one grant on bank %0d", b);
  end

  // Nobody is granted without asking
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((rd_gnt_o & ~rd_req_i) == '0) && (!alu_gnt_o || alu_req_i) && (!ldu_gnt_o || ldu_req_i))
    else $error("grant without a matching request");

endmodule

//--- source/opreq_stage.sv
////////////////////
// Operand request stage of one lane
// Result tracker, four requesters and the VRF arbiter
////////////////////

`timescale 1ns/1ps
`include "opreq_config.svh"

module opreq_stage import opreq_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Read commands
  input  opq_req_t   [`OPREQ_NR_OPQ-1:0]     opq_req_i,
  input  logic       [`OPREQ_NR_OPQ-1:0]     opq_req_valid_i,
  output logic       [`OPREQ_NR_OPQ-1:0]     opq_req_ready_o,
  // Operand queues
  input  logic       [`OPREQ_NR_OPQ-1:0]     opq_ready_i,
  output logic       [`OPREQ_NR_OPQ-1:0]     opq_issued_o,
  output opq_cmd_t   [`OPREQ_NR_OPQ-1:0]     opq_cmd_o,
  output logic       [`OPREQ_NR_OPQ-1:0]     opq_cmd_valid_o,
  input  vinsn_mask_t                        vinsn_running_i,
  // ALU writer
  input  logic                               alu_req_i,
  input  result_req_t                        alu_i,
  output logic                               alu_gnt_o,
  // Load unit writer
  input  logic                               ldu_req_i,
  input  result_req_t                        ldu_i,
  output logic                               ldu_gnt_o,
  // VRF
  output bank_mask_t                         vrf_req_o,
  output vrf_req_t   [`OPREQ_NR_BANKS-1:0]   vrf_o
);

  vinsn_mask_t                        result_written;
  logic                               ldu_req_q;
  result_req_t                        ldu_q;
  logic                               ldu_gnt_q;
  bank_mask_t  [`OPREQ_NR_OPQ-1:0]    rd_req;
  vrf_req_t    [`OPREQ_NR_OPQ-1:0]    rd_pay;
  bank_mask_t  [`OPREQ_NR_OPQ-1:0]    rd_gnt;

  result_tracker u_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ldu_req_i        (ldu_req_i),
    .ldu_i            (ldu_i),
    .ldu_gnt_o        (ldu_gnt_o),
    .ldu_req_o        (ldu_req_q),
    .ldu_o            (ldu_q),
    .ldu_gnt_i        (ldu_gnt_q),
    .alu_gnt_i        (alu_gnt_o),
    .alu_id_i         (alu_i.id),
    .result_written_o (result_written)
  );

  for (genvar q = 0; q < `OPREQ_NR_OPQ; q++) begin : gen_requester
    operand_requester #(
      .QUEUE_ID (opq_id_t'(q))
    ) u_requester (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .req_valid_i      (opq_req_valid_i[q]),
      .req_i            (opq_req_i[q]),
      .req_ready_o      (opq_req_ready_o[q]),
      .opq_ready_i      (opq_ready_i[q]),
      .result_written_i (result_written),
      .vinsn_running_i  (vinsn_running_i),
      .bank_req_o       (rd_req[q]),
      .vrf_o            (rd_pay[q]),
      .bank_gnt_i       (rd_gnt[q]),
      .issued_o         (opq_issued_o[q]),
      .cmd_o            (opq_cmd_o[q]),
      .cmd_valid_o      (opq_cmd_valid_o[q])
    );
  end

  vrf_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_req),
    .rd_i      (rd_pay),
    .rd_gnt_o  (rd_gnt),
    .alu_req_i (alu_req_i),
    .alu_i     (alu_i),
    .alu_gnt_o (alu_gnt_o),
    .ldu_req_i (ldu_req_q),
    .ldu_i     (ldu_q),
    .ldu_gnt_o (ldu_gnt_q),
    .vrf_req_o (vrf_req_o),
    .vrf_o     (vrf_o)
  );

endmodule

//--- sim/tb_opreq_stage.sv
////////////////////
// Testbench of the operand request stage
// Random commands and writes, reference model, checks, watchdog
////////////////////

`timescale 1ns/1ps
`include "opreq_config.svh"

module tb_opreq_stage import opreq_pkg::*; ();

  localparam int NQ          = `OPREQ_NR_OPQ;
  localparam int NB          = `OPREQ_NR_BANKS;
  localparam int CMDS_PER_Q  = 16;
  localparam int N_CMD       = NQ * CMDS_PER_Q;
  localparam int TIMEOUT_CYC = N_CMD * 40 + 200;
  localparam int PERIOD      = 20;

  logic                           clk_i;
  logic                           rst_ni;
  opq_req_t    [NQ-1:0]           opq_req_i;
  logic        [NQ-1:0]           opq_req_valid_i;
  logic        [NQ-1:0]           opq_req_ready_o;
  logic        [NQ-1:0]           opq_ready_i;
  logic        [NQ-1:0]           opq_issued_o;
  opq_cmd_t    [NQ-1:0]           opq_cmd_o;
  logic        [NQ-1:0]           opq_cmd_valid_o;
  vinsn_mask_t                    vinsn_running_i;
  logic                           alu_req_i;
  result_req_t                    alu_i;
  logic                           alu_gnt_o;
  logic                           ldu_req_i;
  result_req_t                    ldu_i;
  logic                           ldu_gnt_o;
  bank_mask_t                     vrf_req_o;
  vrf_req_t    [NB-1:0]           vrf_o;

  // Reference model state
  vaddr_t      exp_addr [NQ];
  int          left [NQ];
  vinsn_mask_t hz [NQ];
  int          n_reads [NQ];
  vinsn_mask_t prev_written;
  result_req_t ldu_fifo [$];
  logic [NQ-1:0] acc_seen;
  logic        alu_done;
  logic        ldu_done;
  int          sent [NQ];
  logic [31:0] rng;
  int          cyc;
  int          err_cnt;

  opreq_stage DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // 8, 4, 2 or 1 elements in a 64-bit word
  function automatic int elems_in_word(input vew_e eew);
    return 8 >> int'(eew);
  endfunction

  function automatic opq_req_t make_command(input logic [31:0] r);
    opq_req_t c;
    c.vs     = r[4:0];
    c.vstart = vlen_t'(r[8:5]);
    c.eew    = vew_e'(r[10:9]);
    c.vl     = (r[18:16] == 3'd0) ? '0 : vlen_t'(r[15:11]);
    c.hazard = (r[20:19] == 2'd0) ? vinsn_mask_t'(1) << r[23:21] : '0;
    return c;
  endfunction

  function automatic result_req_t make_write(input logic [31:0] r);
    result_req_t w;
    w.id    = r[2:0];
    w.addr  = r[10:3];
    w.wdata = {rand_word(), rand_word()};
    w.be    = r[18:11];
    return w;
  endfunction

  function automatic bit busy();
    bit b;
    b = alu_req_i || ldu_req_i || (|opq_req_valid_i);
    for (int q = 0; q < NQ; q++) begin
      if (left[q] != 0) b = 1'b1;
    end
    return b;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_cnt++;
    $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("Error at t=%0t: %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  ////////////////////
  // Reference model and checks
  ////////////////////

  always @(negedge clk_i) begin
    vinsn_mask_t written;
    result_req_t wr;
    opq_id_t     t;
    int          ab;
    int          epw;
    if (!rst_ni) begin
      assert (opq_req_ready_o == '0 && opq_issued_o == '0 && opq_cmd_valid_o == '0 &&
              !alu_gnt_o && !ldu_gnt_o && vrf_req_o == '0)
        else report_failure("outputs active during reset");
      for (int q = 0; q < NQ; q++) begin
        left[q] = 0;
        hz[q]   = '0;
      end
      prev_written = '0;
      acc_seen     = '0;
      alu_done     = 1'b0;
      ldu_done     = 1'b0;
    end else begin
      written = '0;
      ab      = int'(alu_i.addr[`OPREQ_BANK_W-1:0]);
      for (int q = 0; q < NQ; q++) n_reads[q] = 0;
      if (alu_gnt_o) begin
        written[alu_i.id] = 1'b1;
        assert (vrf_req_o[ab] && vrf_o[ab].wen)
          else report_failure("ALU grant not on its bank");
      end
      for (int b = 0; b < NB; b++) begin
        if (vrf_req_o[b] && vrf_o[b].wen) begin
          if (alu_gnt_o && ab == b) begin
            wr = alu_i;
          end else begin
            assert (ldu_fifo.size() > 0) else report_failure("bank write without a pending load");
            wr = ldu_fifo.pop_front();
            written[wr.id] = 1'b1;
            assert (int'(wr.addr[`OPREQ_BANK_W-1:0]) == b)
              else report_mismatch("load bank", wr.addr[`OPREQ_BANK_W-1:0], b);
          end
          assert (vrf_o[b].addr == wr.addr[7:2])
            else report_mismatch("vrf_o.addr", wr.addr[7:2], vrf_o[b].addr);
          assert (vrf_o[b].wdata == wr.wdata)
            else report_mismatch("vrf_o.wdata", wr.wdata, vrf_o[b].wdata);
          assert (vrf_o[b].be == wr.be) else report_mismatch("vrf_o.be", wr.be, vrf_o[b].be);
        end else if (vrf_req_o[b]) begin
          t = vrf_o[b].tgt_opq;
          n_reads[t]++;
          assert (left[t] > 0) else report_failure("read with no command pending");
          assert (int'(exp_addr[t][1:0]) == b) else report_mismatch("read bank", exp_addr[t][1:0], b);
          assert (vrf_o[b].addr == exp_addr[t][7:2])
            else report_mismatch("vrf_o.addr", exp_addr[t][7:2], vrf_o[b].addr);
          assert (opq_ready_i[t]) else report_failure("read while the operand queue is full");
          assert ((hz[t] & ~prev_written) == '0) else report_failure("read under an open hazard");
          assert (!(t >= 2 && alu_req_i && ab == b))
            else report_failure("low class read won a bank held by the ALU");
          exp_addr[t] = exp_addr[t] + 1'b1;
          left[t]     = left[t] - 1;
        end
      end

      // The stream register holds one word
      assert (!ldu_gnt_o || ldu_fifo.size() == 0)
        else report_failure("load accepted while the stream register is full");
      if (ldu_gnt_o) ldu_fifo.push_back(ldu_i);

      for (int q = 0; q < NQ; q++) begin
        assert (n_reads[q] <= 1 && opq_issued_o[q] == (n_reads[q] == 1))
          else report_mismatch("opq_issued_o", n_reads[q], opq_issued_o[q]);
        assert (opq_req_ready_o[q] == (opq_req_valid_i[q] && left[q] == 0))
          else report_mismatch("opq_req_ready_o", opq_req_valid_i[q] && left[q] == 0,
                               opq_req_ready_o[q]);
        hz[q]       = hz[q] & vinsn_running_i;
        acc_seen[q] = opq_req_valid_i[q] && opq_req_ready_o[q];
        if (acc_seen[q]) begin
          epw = elems_in_word(opq_req_i[q].eew);
          assert (opq_cmd_valid_o[q] == (opq_req_i[q].vl != '0))
            else report_mismatch("opq_cmd_valid_o", opq_req_i[q].vl != '0, opq_cmd_valid_o[q]);
          assert (!opq_cmd_valid_o[q] || (opq_cmd_o[q].eew == opq_req_i[q].eew &&
                                          opq_cmd_o[q].vl == opq_req_i[q].vl))
            else report_mismatch("opq_cmd_o", {opq_req_i[q].eew, opq_req_i[q].vl}, opq_cmd_o[q]);
          exp_addr[q] = vaddr_t'(int'(opq_req_i[q].vs) * `OPREQ_VREG_WORDS +
                                 int'(opq_req_i[q].vstart) / epw);
          left[q]     = (int'(opq_req_i[q].vl) + epw - 1) / epw;
          hz[q]       = opq_req_i[q].hazard;
        end else begin
          assert (!opq_cmd_valid_o[q])
            else report_failure("cmd_valid without an accepted command");
        end
      end
      prev_written = written;
      alu_done     = alu_gnt_o;
      ldu_done     = ldu_gnt_o;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Drive one cycle of inputs and let everything drain when traffic is off
  task automatic drive_inputs(input bit traffic);
    logic [31:0] r;
    for (int q = 0; q < NQ; q++) begin
      r = rand_word();
      if (opq_req_valid_i[q] && acc_seen[q]) opq_req_valid_i[q] = 1'b0;
      if (traffic && !opq_req_valid_i[q] && sent[q] < CMDS_PER_Q && r[0]) begin
        opq_req_i[q]       = make_command(rand_word());
        opq_req_valid_i[q] = 1'b1;
        sent[q]++;
      end
      opq_ready_i[q] = !traffic || (r[3:1] != 3'd0);
    end
    r = rand_word();
    if (alu_req_i && alu_done) alu_req_i = 1'b0;
    if (traffic && !alu_req_i && r[1:0] != 2'd0) begin
      alu_i     = make_write(rand_word());
      alu_req_i = 1'b1;
    end
    if (ldu_req_i && ldu_done) ldu_req_i = 1'b0;
    if (traffic && !ldu_req_i && r[3:2] != 2'd0) begin
      ldu_i     = make_write(rand_word());
      ldu_req_i = 1'b1;
    end
    // Running ids are refreshed now and then and retire one by one
    if (!traffic) begin
      vinsn_running_i = '0;
    end else if (cyc % 16 == 0) begin
      vinsn_running_i = r[15:8];
    end else if (r[5:4] == 2'd0) begin
      vinsn_running_i[r[18:16]] = 1'b0;
    end
    cyc++;
  endtask

  initial begin
    rng             = 32'd63;
    err_cnt         = 0;
    cyc             = 0;
    rst_ni          = 1'b0;
    opq_req_i       = '0;
    opq_req_valid_i = '0;
    opq_ready_i     = '0;
    vinsn_running_i = '0;
    alu_req_i       = 1'b0;
    alu_i           = '0;
    ldu_req_i       = 1'b0;
    ldu_i           = '0;
    for (int q = 0; q < NQ; q++) sent[q] = 0;
    repeat (4) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    while (sent.sum() < N_CMD || (|opq_req_valid_i)) begin
      @(posedge clk_i);
      #2 drive_inputs(1'b1);
    end
    while (busy()) begin
      @(posedge clk_i);
      #2 drive_inputs(1'b0);
    end
    repeat (2) @(posedge clk_i);

    assert (ldu_fifo.size() == 0) else report_failure("a load write never reached its bank");
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sources.f
+incdir+source
source/opreq_pkg.sv
source/result_tracker.sv
source/operand_requester.sv
source/vrf_arbiter.sv
source/opreq_stage.sv
sim/tb_opreq_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the operand request stage testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_opreq_stage -j 0

# The log decides the result, a fatal stop leaves no pass line
./obj_dir/Vtb_opreq_stage > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test completed successfully" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
